// ==== Bender.yml ====
package:
  name: uart

sources:
  - rtl/uart_pkg.sv
  - rtl/bit_timer.sv
  - rtl/uart_rx.sv
  - rtl/uart_tx.sv
  - rtl/uart_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_uart.sv

// ==== project.f ====
+incdir+tb
rtl/uart_pkg.sv
rtl/bit_timer.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_top.sv
tb/tb_uart.sv

// ==== rtl/bit_timer.sv ====
`timescale 1ns/1ps

module bit_timer #(
  parameter int BIT_PERIOD = 16,
  parameter int TIM_WIDTH  = 16
) (
  input  logic                rst,
  input  logic                clk,
  input  logic                clear,
  output uart_pkg::bit_tick_t tick
);

  typedef logic [TIM_WIDTH-1:0] count_t;

  localparam count_t period_c = count_t'(BIT_PERIOD);
  localparam count_t half_c   = count_t'(BIT_PERIOD / 2);

  count_t count;
  count_t count_inc;
  count_t count_next;

  assign count_inc  = count + count_t'(1);
  assign count_next = (count_inc < period_c) ? count_inc : '0; // wrap at period

  assign tick.full = (count_next == '0);
  assign tick.half = (count == half_c);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      count <= '0;
    end else if (clear) begin
      count <= '0; // held by owner while idle
    end else begin
      count <= count_next;
    end
  end

endmodule

// ==== rtl/uart_pkg.sv ====
package uart_pkg;

  // 8N1 framing, lsb first
  localparam int data_bits = 8;

  // one character on either side
  typedef logic [data_bits-1:0] uart_byte_t;

  // which data bit is on the line
  typedef logic [$clog2(data_bits)-1:0] bit_idx_t;

  // shared by the rx and tx state machines
  typedef enum logic [1:0] {
    idle,  // line high, waiting
    start, // start bit
    data,  // data bits
    stop   // stop bit
  } frame_state_t;

  // strobes from bit_timer
  typedef struct packed {
    logic half; // middle of the bit
    logic full; // counter wraps on next edge
  } bit_tick_t;

  // receive shift register with its bit counter
  typedef struct packed {
    uart_byte_t shift;
    bit_idx_t   idx;
  } rx_frame_t;

endpackage

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
  input  logic                 rst,
  input  logic                 clk,
  input  logic                 rx,
  input  uart_pkg::bit_tick_t  tick,
  output logic                 timer_clear,
  input  logic                 rd,
  output uart_pkg::uart_byte_t rx_data,
  output logic                 rx_full
);

  localparam int filter_len = 4;
  localparam uart_pkg::bit_idx_t last_idx = uart_pkg::bit_idx_t'(uart_pkg::data_bits - 1);

  logic [filter_len-1:0]  window;
  logic                   line;   // filtered rx
  uart_pkg::frame_state_t state;
  uart_pkg::frame_state_t state_next;
  uart_pkg::rx_frame_t    frame;
  logic                   load;

  // sample window, newest sample at the top
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      window <= '1;
    end else begin
      window <= {rx, window[filter_len-1:1]};
    end
  end

  // only moves on a full run of equal samples
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      line <= 1'b1;
    end else if (&window) begin
      line <= 1'b1;
    end else if (~|window) begin
      line <= 1'b0;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      uart_pkg::idle: begin
        if (!line) begin
          state_next = uart_pkg::start; // falling edge
        end
      end
      uart_pkg::start: begin
        if (tick.full) begin
          state_next = uart_pkg::data;
        end
      end
      uart_pkg::data: begin
        if (tick.full && frame.idx == last_idx) begin
          state_next = uart_pkg::stop;
        end
      end
      uart_pkg::stop: begin
        if (tick.half) begin
          state_next = uart_pkg::idle; // leave early, stop bit not checked
        end
      end
      default: begin
        state_next = uart_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state <= uart_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  assign timer_clear = (state == uart_pkg::idle);
  assign load        = (state == uart_pkg::stop) && tick.half;

  // data bits arrive lsb first
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      frame <= '0;
    end else if (state == uart_pkg::idle) begin
      frame.idx <= '0;
    end else if (state == uart_pkg::data) begin
      if (tick.half) begin
        frame.shift <= {line, frame.shift[uart_pkg::data_bits-1:1]};
      end
      if (tick.full) begin
        frame.idx <= frame.idx + uart_pkg::bit_idx_t'(1);
      end
    end
  end

  // one-deep holding buffer, overwritten on overrun
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rx_data <= '0;
      rx_full <= 1'b0;
    end else if (load) begin
      rx_data <= frame.shift;
      rx_full <= 1'b1; // new byte wins over rd
    end else if (rd) begin
      rx_full <= 1'b0;
    end
  end

endmodule

// ==== rtl/uart_top.sv ====
`timescale 1ns/1ps

module uart_top #(
  parameter int CLOCK_HZ  = 1_000_000,
  parameter int BAUD      = 62_500,
  parameter int TIM_WIDTH = 16
) (
  input  logic                 rst,
  input  logic                 clk,
  input  logic                 rx,
  output logic                 tx,
  input  uart_pkg::uart_byte_t tx_data,
  input  logic                 wr,
  output logic                 tx_ready,
  output uart_pkg::uart_byte_t rx_data,
  output logic                 rx_full,
  input  logic                 rd
);

  localparam int BIT_PERIOD = CLOCK_HZ / BAUD; // clocks per bit

  uart_pkg::bit_tick_t rx_tick;
  uart_pkg::bit_tick_t tx_tick;
  logic                rx_timer_clear;
  logic                tx_timer_clear;

  bit_timer #(
    .BIT_PERIOD(BIT_PERIOD),
    .TIM_WIDTH (TIM_WIDTH)
  ) u_rx_timer (
    .rst  (rst),
    .clk  (clk),
    .clear(rx_timer_clear),
    .tick (rx_tick)
  );

  bit_timer #(
    .BIT_PERIOD(BIT_PERIOD),
    .TIM_WIDTH (TIM_WIDTH)
  ) u_tx_timer (
    .rst  (rst),
    .clk  (clk),
    .clear(tx_timer_clear),
    .tick (tx_tick)
  );

  uart_rx u_rx (
    .rst        (rst),
    .clk        (clk),
    .rx         (rx),
    .tick       (rx_tick),
    .timer_clear(rx_timer_clear),
    .rd         (rd),
    .rx_data    (rx_data),
    .rx_full    (rx_full)
  );

  uart_tx u_tx (
    .rst        (rst),
    .clk        (clk),
    .tick       (tx_tick),
    .timer_clear(tx_timer_clear),
    .tx_data    (tx_data),
    .wr         (wr),
    .tx_ready   (tx_ready),
    .tx         (tx)
  );

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
  input  logic                 rst,
  input  logic                 clk,
  input  uart_pkg::bit_tick_t  tick,
  output logic                 timer_clear,
  input  uart_pkg::uart_byte_t tx_data,
  input  logic                 wr,
  output logic                 tx_ready,
  output logic                 tx
);

  localparam uart_pkg::bit_idx_t last_idx = uart_pkg::bit_idx_t'(uart_pkg::data_bits - 1);

  uart_pkg::frame_state_t state;
  uart_pkg::frame_state_t state_next;
  uart_pkg::uart_byte_t   shift;
  uart_pkg::bit_idx_t     idx;
  logic                   accept;

  assign accept = (state == uart_pkg::idle) && wr; // wr while busy is dropped

  always_comb begin
    state_next = state;
    case (state)
      uart_pkg::idle: begin
        if (wr) begin
          state_next = uart_pkg::start;
        end
      end
      uart_pkg::start: begin
        if (tick.full) begin
          state_next = uart_pkg::data;
        end
      end
      uart_pkg::data: begin
        if (tick.full && idx == last_idx) begin
          state_next = uart_pkg::stop;
        end
      end
      uart_pkg::stop: begin
        if (tick.full) begin
          state_next = uart_pkg::idle;
        end
      end
      default: begin
        state_next = uart_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state <= uart_pkg::idle;
      idx   <= '0;
    end else begin
      state <= state_next;
      if (state == uart_pkg::idle) begin
        idx <= '0;
      end else if (state == uart_pkg::data && tick.full) begin
        idx <= idx + uart_pkg::bit_idx_t'(1);
      end
    end
  end

  // lsb goes out first
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      shift <= '0;
    end else if (accept) begin
      shift <= tx_data;
    end else if (state == uart_pkg::data && tick.full) begin
      shift <= {1'b0, shift[uart_pkg::data_bits-1:1]};
    end
  end

  always_comb begin
    case (state)
      uart_pkg::start: tx = 1'b0;
      uart_pkg::data:  tx = shift[0];
      default:         tx = 1'b1; // idle and stop
    endcase
  end

  assign timer_clear = (state == uart_pkg::idle);
  assign tx_ready    = (state == uart_pkg::idle) && !wr;

endmodule

// ==== tb/tb_uart_model.svh ====
// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
  logic fb;
  fb = state[15] ^ state[13] ^ state[12] ^ state[10];
  return {state[14:0], fb};
endfunction

// one lfsr step per bit taken
task automatic take_random_byte(output uart_pkg::uart_byte_t b);
  int k;
  for (k = 0; k < uart_pkg::data_bits; k++) begin
    lfsr_state = lfsr_step(lfsr_state);
    b[k] = lfsr_state[0];
  end
endtask

// index 0 goes on the line first
function automatic logic [9:0] frame_bits(input uart_pkg::uart_byte_t b);
  return {1'b1, b, 1'b0}; // stop, data, start
endfunction

// drives rx in whole bit periods
task automatic drive_frame(input uart_pkg::uart_byte_t b);
  logic [9:0] bits;
  int         i;
  bits = frame_bits(b);
  @(posedge rst);
  #drive_delay;
  for (i = 0; i < 10; i++) begin
    drv_rx = bits[i];
    repeat (bit_period) @(posedge rst);
    #drive_delay;
  end
  drv_rx = 1'b1;
endtask

// samples tx mid-bit, counted from the first low cycle
task automatic capture_frame(
  output logic [9:0] bits,
  output int         ready_high,
  output bit         seen,
  input  int         max_wait
);
  int waited;
  int i;
  bits       = '1;
  ready_high = 0;
  seen       = 1'b0;
  waited     = 0;
  while (!seen && waited < max_wait) begin
    @(negedge rst);
    if (tx == 1'b0) begin
      seen = 1'b1;
    end
    waited++;
  end
  if (seen) begin
    repeat (bit_period / 2) @(negedge rst);
    for (i = 0; i < 10; i++) begin
      if (i > 0) begin
        repeat (bit_period) @(negedge rst);
      end
      bits[i] = tx;
      if (tx_ready) begin
        ready_high++;
      end
    end
  end
endtask

// ==== tb/tb_uart.sv ====
`timescale 1ns/1ps

module tb_uart;

  localparam int clock_hz        = 1_000_000;
  localparam int baud            = 62_500;
  localparam int bit_period      = clock_hz / baud;
  localparam int frame_cycles    = 10 * bit_period;
  localparam int num_frames      = 28; // incl. the quiet windows of the glitch test
  localparam int watchdog_cycles = num_frames * frame_cycles * 2 + 1000;
  localparam int drive_delay     = 1;
  localparam int loop_bytes      = 20;

  logic                 rst; // clock
  logic                 clk; // async reset, active high
  logic                 rx_line;
  logic                 tx;
  uart_pkg::uart_byte_t tx_data;
  logic                 wr;
  logic                 tx_ready;
  uart_pkg::uart_byte_t rx_data;
  logic                 rx_full;
  logic                 rd;
  logic                 loop_sel; // 1 loops tx back to rx
  logic                 drv_rx;
  logic [15:0]          lfsr_state;
  logic                 rx_full_q;
  uart_pkg::uart_byte_t exp_byte;
  uart_pkg::uart_byte_t expected_q[$];
  int                   errors;
  int                   compares;
  int                   tests;

  `include "tb_uart_model.svh"

  assign rx_line = loop_sel ? tx : drv_rx;

  uart_top #(
    .CLOCK_HZ(clock_hz),
    .BAUD    (baud)
  ) u_dut (
    .rst     (rst),
    .clk     (clk),
    .rx      (rx_line),
    .tx      (tx),
    .tx_data (tx_data),
    .wr      (wr),
    .tx_ready(tx_ready),
    .rx_data (rx_data),
    .rx_full (rx_full),
    .rd      (rd)
  );

  always #5 rst = ~rst;

  initial begin
    repeat (watchdog_cycles) @(posedge rst);
    $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
    $display("Something failed");
    $finish;
  end

  task automatic next_cycle();
    @(posedge rst);
    #drive_delay;
  endtask

  task automatic report_mismatch(input string msg);
    errors++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("at %0t ns something went wrong: %s", $time, msg);
  endtask

  task automatic close_test(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %0d %s: passed", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - err0);
    end
  endtask

  task automatic write_byte(input uart_pkg::uart_byte_t b);
    next_cycle();
    tx_data = b;
    wr      = 1'b1;
    next_cycle();
    wr      = 1'b0;
  endtask

  task automatic wait_tx_ready(input int max_cycles);
    int n;
    n = 0;
    @(negedge rst);
    while (!tx_ready && n < max_cycles) begin
      @(negedge rst);
      n++;
    end
    if (!tx_ready) begin
      report_problem("tx_ready never came back high");
    end
  endtask

  task automatic read_and_clear(input int max_cycles);
    int n;
    n = 0;
    @(negedge rst);
    while (!rx_full && n < max_cycles) begin
      @(negedge rst);
      n++;
    end
    if (!rx_full) begin
      report_problem("no byte arrived, rx_full stayed low");
    end else begin
      next_cycle();
      rd = 1'b1;
      next_cycle();
      rd = 1'b0;
      @(negedge rst);
      if (rx_full !== 1'b0) begin
        report_mismatch("rx_full still high after rd");
      end
    end
  endtask

  task automatic check_frame(
    input logic [9:0]           got,
    input uart_pkg::uart_byte_t b,
    input int                   ready_high,
    input bit                   seen
  );
    logic [9:0] want;
    want = frame_bits(b);
    if (!seen) begin
      report_problem("tx never went low for a start bit");
    end else begin
      if (got !== want) begin
        report_mismatch($sformatf("tx frame %b, expected %b (byte %02h)", got, want, b));
      end
      if (ready_high != 0) begin
        report_mismatch($sformatf("tx_ready high at %0d mid-bit samples", ready_high));
      end
    end
  endtask

  task automatic check_no_byte(input int cycles);
    int n;
    int hits;
    hits = 0;
    for (n = 0; n < cycles; n++) begin
      @(negedge rst);
      if (rx_full) begin
        hits++;
      end
    end
    if (hits != 0) begin
      report_mismatch($sformatf("rx_full high for %0d cycles after a glitch", hits));
    end
  endtask

  task automatic check_line_idle(input int cycles);
    int n;
    int busy;
    busy = 0;
    for (n = 0; n < cycles; n++) begin
      @(negedge rst);
      if (tx !== 1'b1 || tx_ready !== 1'b1) begin
        busy++;
      end
    end
    if (busy != 0) begin
      report_mismatch($sformatf("tx busy for %0d cycles after the frame", busy));
    end
  endtask

  // checks each new byte against the oldest expected one
  always @(negedge rst) begin
    if (rx_full && !rx_full_q) begin
      if (expected_q.size() == 0) begin
        report_problem("rx_full rose but no byte was expected");
      end else begin
        exp_byte = expected_q.pop_front();
        compares++;
        if (rx_data !== exp_byte) begin
          report_mismatch($sformatf("rx_data %02h, expected %02h", rx_data, exp_byte));
        end
      end
    end
    rx_full_q = rx_full;
  end

  initial begin : test_sequence
    uart_pkg::uart_byte_t b;
    uart_pkg::uart_byte_t b2;
    logic [9:0]           got;
    int                   ready_high;
    bit                   seen;
    int                   err0;
    int                   i;
    rst        = 1'b0;
    clk        = 1'b1;
    tx_data    = '0;
    wr         = 1'b0;
    rd         = 1'b0;
    loop_sel   = 1'b1;
    drv_rx     = 1'b1;
    rx_full_q  = 1'b0;
    lfsr_state = 16'd38781;
    errors     = 0;
    compares   = 0;
    tests      = 0;
    repeat (10) @(posedge rst);
    #drive_delay;
    clk = 1'b0;
    repeat (2) next_cycle();

    err0 = errors;
    @(negedge rst);
    if (tx !== 1'b1) begin
      report_mismatch($sformatf("tx %b after reset, expected 1", tx));
    end
    if (tx_ready !== 1'b1) begin
      report_mismatch($sformatf("tx_ready %b after reset, expected 1", tx_ready));
    end
    if (rx_full !== 1'b0) begin
      report_mismatch($sformatf("rx_full %b after reset, expected 0", rx_full));
    end
    if (rx_data !== '0) begin
      report_mismatch($sformatf("rx_data %02h after reset, expected 00", rx_data));
    end
    close_test("reset values", err0);

    err0 = errors;
    take_random_byte(b);
    expected_q.push_back(b);
    fork
      capture_frame(got, ready_high, seen, 4 * bit_period);
      write_byte(b);
    join
    check_frame(got, b, ready_high, seen);
    wait_tx_ready(2 * bit_period);
    read_and_clear(frame_cycles);
    close_test("tx framing", err0);

    err0 = errors;
    for (i = 0; i < loop_bytes; i++) begin
      take_random_byte(b);
      expected_q.push_back(b);
      wait_tx_ready(2 * frame_cycles);
      write_byte(b);
      read_and_clear(2 * frame_cycles);
    end
    close_test("loopback", err0);

    err0 = errors;
    next_cycle();
    loop_sel = 1'b0;
    for (i = 1; i <= 3; i++) begin
      drv_rx = 1'b0; // shorter than the filter window
      repeat (i) next_cycle();
      drv_rx = 1'b1;
      repeat (8) next_cycle();
    end
    check_no_byte(2 * frame_cycles);
    take_random_byte(b);
    expected_q.push_back(b);
    drive_frame(b);
    read_and_clear(frame_cycles);
    close_test("glitch rejection", err0);

    err0 = errors;
    take_random_byte(b);
    take_random_byte(b2);
    if (b2 == b) begin
      b2 = ~b;
    end
    expected_q.push_back(b); // only the first one raises rx_full
    drive_frame(b);
    drive_frame(b2);
    @(negedge rst);
    if (rx_full !== 1'b1) begin
      report_mismatch("rx_full low after two unread frames");
    end
    if (rx_data !== b2) begin
      report_mismatch($sformatf("rx_data %02h after overrun, expected %02h", rx_data, b2));
    end
    read_and_clear(frame_cycles);
    next_cycle();
    loop_sel = 1'b1;
    take_random_byte(b);
    b2 = ~b;
    expected_q.push_back(b);
    fork
      capture_frame(got, ready_high, seen, 4 * bit_period);
      begin
        write_byte(b);
        repeat (5 * bit_period) next_cycle();
        write_byte(b2); // transmitter busy here
      end
    join
    check_frame(got, b, ready_high, seen);
    wait_tx_ready(2 * bit_period);
    read_and_clear(frame_cycles);
    check_line_idle(3 * bit_period);
    close_test("overrun and ignored write", err0);

    if (expected_q.size() != 0) begin
      report_problem($sformatf("%0d expected bytes never arrived", expected_q.size()));
    end
    $display("tests %0d, byte compares %0d, errors %0d", tests, compares, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
